// ==== maPkg.sv ====
//////////////////////////////
// Shared types and default pipeline depths of the multiply-add unit
// Integer datapath only, no floating point variants
//////////////////////////////
`default_nettype none

package maPkg;

	//////////////////////////////
	// Datapath words
	//////////////////////////////

	// Operand and result word
	typedef logic [31:0] dataT;

	// Tag, carried unchanged from issue to result
	typedef logic [3:0] tagT;

	//////////////////////////////
	// Operation classes
	//////////////////////////////

	// Code 2'b11 is reserved and decodes to no operation
	typedef enum logic [1:0] {
		opAdd    = 2'b00,	// data1 + data2
		opMul    = 2'b01,	// Low word of data1 * data2
		opMulAdd = 2'b10	// data1 * data2 + data3
	} opT;

	//////////////////////////////
	// Default latencies
	//////////////////////////////

	// Multiplier stages, also the depth of the addend buffer
	localparam int defaultDepthMul = 3;

	// Adder stages
	localparam int defaultDepthAdd = 1;

endpackage

`default_nettype wire

// ==== maAdder.sv ====
//////////////////////////////
// Pipelined integer adder, result after depth cycles
// depth must be 1 or more
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module maAdder #(
	parameter int depth = 1
) (
	input  logic       clock,
	input  logic       rstN,
	input  logic       en,
	input  maPkg::dataT a,
	input  maPkg::dataT b,
	input  maPkg::tagT  tagIn,
	output logic       valid,
	output maPkg::dataT sum,
	output maPkg::tagT  tagOut
);
	import maPkg::*;

	logic [depth-1:0] validQ;
	dataT             sumQ [depth];
	tagT              tagQ [depth];

	// Valid chain, the only reset state
	always_ff @(posedge clock) begin
		if (!rstN) begin
			validQ <= '0;
		end else begin
			validQ[0] <= en;
			for (int i = 1; i < depth; i++) begin
				validQ[i] <= validQ[i-1];
			end
		end
	end

	// Sum formed in the first stage, then only delayed
	always_ff @(posedge clock) begin
		sumQ[0] <= a + b;
		tagQ[0] <= tagIn;
		for (int i = 1; i < depth; i++) begin
			sumQ[i] <= sumQ[i-1];
			tagQ[i] <= tagQ[i-1];
		end
	end

	assign valid  = validQ[depth-1];
	assign sum    = sumQ[depth-1];
	assign tagOut = tagQ[depth-1];

endmodule

`default_nettype wire

// ==== maMultiplier.sv ====
//////////////////////////////
// Pipelined integer multiplier, keeps the low 32 bits of the product
// Chain flag marks a product that continues into the adder
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module maMultiplier #(
	parameter int depth = 3
) (
	input  logic       clock,
	input  logic       rstN,
	input  logic       en,
	input  maPkg::dataT a,
	input  maPkg::dataT b,
	input  maPkg::tagT  tagIn,
	input  logic       chainIn,
	output logic       valid,
	output maPkg::dataT product,
	output maPkg::tagT  tagOut,
	output logic       chainOut
);
	import maPkg::*;

	logic [depth-1:0] validQ;
	logic [depth-1:0] chainQ;
	dataT             prodQ [depth];
	tagT              tagQ [depth];

	//////////////////////////////
	// Control chain
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (!rstN) begin
			validQ <= '0;
		end else begin
			validQ[0] <= en;
			for (int i = 1; i < depth; i++) begin
				validQ[i] <= validQ[i-1];
			end
		end
	end

	//////////////////////////////
	// Payload
	//////////////////////////////
	always_ff @(posedge clock) begin
		prodQ[0]  <= a * b;	// Upper half dropped
		tagQ[0]   <= tagIn;
		chainQ[0] <= chainIn;	// Only meaningful with validQ
		for (int i = 1; i < depth; i++) begin
			prodQ[i]  <= prodQ[i-1];
			tagQ[i]   <= tagQ[i-1];
			chainQ[i] <= chainQ[i-1];
		end
	end

	assign valid    = validQ[depth-1];
	assign product  = prodQ[depth-1];
	assign tagOut   = tagQ[depth-1];
	assign chainOut = chainQ[depth-1];

endmodule

`default_nettype wire

// ==== addendBuffer.sv ====
//////////////////////////////
// Ring buffer holding the third operand of each MULADD in flight
// popData shows the oldest entry, valid only while not empty
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module addendBuffer #(
	parameter int numEntry = 3
) (
	input  logic       clock,
	input  logic       rstN,
	input  logic       push,
	input  maPkg::dataT pushData,
	input  logic       pop,
	output maPkg::dataT popData,
	output logic       full,
	output logic       empty
);
	import maPkg::*;

	localparam int ptrW = (numEntry > 1) ? $clog2(numEntry) : 1;
	localparam int cntW = $clog2(numEntry + 1);

	dataT            mem [numEntry];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic            doPush;
	logic            doPop;

	// A full buffer still takes a push when the oldest entry leaves
	assign doPush = push & (~full | pop);
	assign doPop  = pop & ~empty;

	always_ff @(posedge clock) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	//////////////////////////////
	// Pointers and occupancy
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == ptrW'(numEntry - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (rdPtr == ptrW'(numEntry - 1)) ? '0 : rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	assign popData = mem[rdPtr];
	assign full    = (count == cntW'(numEntry));
	assign empty   = (count == '0);

endmodule

`default_nettype wire

// ==== issueTracker.sv ====
//////////////////////////////
// Reserves adder input and result port ahead of time
// Bit k of each vector stands for the cycle k cycles from now
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module issueTracker #(
	parameter int depthMul = 3,
	parameter int depthAdd = 1
) (
	input  logic clock,
	input  logic rstN,
	input  logic acceptAdd,
	input  logic acceptMul,
	input  logic acceptMulAdd,
	output logic addBusy,
	output logic mulSlotBusy,
	output logic chainSlotBusy
);

	localparam int resLen = depthMul + depthAdd;	// Furthest offset, a MULADD result

	logic [resLen:1]   resPort;	// Result port reservations
	logic [resLen:1]   resSet;
	logic [depthMul:0] addIn;	// Adder input, bit 0 is this cycle
	logic [depthMul:0] addSet;

	//////////////////////////////
	// New reservations per class
	//////////////////////////////
	always_comb begin
		resSet = '0;
		addSet = '0;
		if (acceptAdd) begin
			resSet[depthAdd] = 1'b1;
		end
		if (acceptMul) begin
			resSet[depthMul] = 1'b1;
		end
		if (acceptMulAdd) begin
			addSet[depthMul] = 1'b1;	// Chain pulse slot
			resSet[resLen]   = 1'b1;
		end
	end

	// Both vectors move one step toward the present
	always_ff @(posedge clock) begin
		if (!rstN) begin
			resPort <= '0;
			addIn   <= '0;
		end else begin
			resPort <= (resPort | resSet) >> 1;
			addIn   <= (addIn | addSet) >> 1;
		end
	end

	//////////////////////////////
	// Conflict levels
	//////////////////////////////

	// An ADD uses the adder input now and the port depthAdd later
	assign addBusy = resPort[depthAdd] | addIn[0];

	assign mulSlotBusy = resPort[depthMul];

	// MULADD needs both the chain slot and the late result slot
	assign chainSlotBusy = addIn[depthMul] | resPort[resLen];

endmodule

`default_nettype wire

// ==== maUnit.sv ====
//////////////////////////////
// Integer multiply-add unit with fixed latency per class
// No output back-pressure, source must honour addBusy and mulBusy
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module maUnit #(
	parameter int depthMul = maPkg::defaultDepthMul,
	parameter int depthAdd = maPkg::defaultDepthAdd
) (
	input  logic        clock,
	input  logic        rstN,
	input  logic        en,
	input  maPkg::opT   op,
	input  maPkg::tagT  tag,
	input  maPkg::dataT data1,
	input  maPkg::dataT data2,
	input  maPkg::dataT data3,
	output logic        valid,
	output maPkg::dataT result,
	output maPkg::tagT  resultTag,
	output logic        addBusy,
	output logic        mulBusy
);
	import maPkg::*;

	logic isAdd;
	logic isMul;
	logic isMulAdd;
	logic acceptAdd;
	logic acceptMul;
	logic acceptMulAdd;
	logic mulSlotBusy;
	logic chainSlotBusy;

	logic mulValid;
	dataT mulProduct;
	tagT  mulTag;
	logic mulChain;
	logic chainPulse;

	logic addEn;
	dataT addA;
	dataT addB;
	tagT  addTagIn;
	logic addValid;
	dataT addSum;
	tagT  addTag;
	dataT addend;

	//////////////////////////////
	// Issue decode
	//////////////////////////////
	assign isAdd    = en & (op == opAdd);
	assign isMul    = en & (op == opMul);
	assign isMulAdd = en & (op == opMulAdd);	// Reserved code matches none

	assign mulBusy = (op == opMulAdd) ? chainSlotBusy : mulSlotBusy;

	assign acceptAdd    = isAdd & ~addBusy;
	assign acceptMul    = isMul & ~mulSlotBusy;
	assign acceptMulAdd = isMulAdd & ~chainSlotBusy;

	issueTracker #(
		.depthMul (depthMul),
		.depthAdd (depthAdd)
	) u_tracker (
		.clock         (clock),
		.rstN          (rstN),
		.acceptAdd     (acceptAdd),
		.acceptMul     (acceptMul),
		.acceptMulAdd  (acceptMulAdd),
		.addBusy       (addBusy),
		.mulSlotBusy   (mulSlotBusy),
		.chainSlotBusy (chainSlotBusy)
	);

	//////////////////////////////
	// Multiplier and addend buffer
	//////////////////////////////
	maMultiplier #(
		.depth (depthMul)
	) u_mul (
		.clock    (clock),
		.rstN     (rstN),
		.en       (acceptMul | acceptMulAdd),
		.a        (data1),
		.b        (data2),
		.tagIn    (tag),
		.chainIn  (acceptMulAdd),
		.valid    (mulValid),
		.product  (mulProduct),
		.tagOut   (mulTag),
		.chainOut (mulChain)
	);

	// Product bound for the adder this cycle
	assign chainPulse = mulValid & mulChain;

	// At most depthMul MULADDs can be in flight
	addendBuffer #(
		.numEntry (depthMul)
	) u_addend (
		.clock    (clock),
		.rstN     (rstN),
		.push     (acceptMulAdd),
		.pushData (data3),
		.pop      (chainPulse),
		.popData  (addend),
		.full     (),
		.empty    ()
	);

	//////////////////////////////
	// Adder input select
	//////////////////////////////
	assign addEn    = chainPulse | acceptAdd;	// Tracker keeps these apart
	assign addA     = chainPulse ? mulProduct : data1;
	assign addB     = chainPulse ? addend : data2;
	assign addTagIn = chainPulse ? mulTag : tag;

	maAdder #(
		.depth (depthAdd)
	) u_add (
		.clock  (clock),
		.rstN   (rstN),
		.en     (addEn),
		.a      (addA),
		.b      (addB),
		.tagIn  (addTagIn),
		.valid  (addValid),
		.sum    (addSum),
		.tagOut (addTag)
	);

	//////////////////////////////
	// Result port
	//////////////////////////////

	// Adder and plain multiplier results never coincide
	assign valid     = addValid | (mulValid & ~mulChain);
	assign result    = addValid ? addSum : mulProduct;
	assign resultTag = addValid ? addTag : mulTag;

endmodule

`default_nettype wire

// ==== tbClock.sv ====
//////////////////////////////
// Testbench clock and reset, reset released 1 ns after an edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int halfPeriod  = 10,
	parameter int resetCycles = 8
) (
	output logic clock,
	output logic rstN
);

	initial begin
		clock = 1'b0;
		forever #(halfPeriod) clock = ~clock;
	end

	// Low for resetCycles rising edges
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		#1 rstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== maUnit_asserts.sv ====
//////////////////////////////
// Assertions bound into the addend buffer and the unit top level
// Inputs a binding has no use for are tied low
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module maUnitAsserts (
	input logic clock,
	input logic rstN,
	input logic push,
	input logic pop,
	input logic full,
	input logic empty,
	input logic addClaim,
	input logic chainClaim,
	input logic addOut,
	input logic mulOut
);

	// A full buffer takes a push only while its oldest entry leaves
	pushWhenFull: assert property (@(posedge clock) disable iff (!rstN)
		!(push && full && !pop))
		else $error("addend buffer pushed while full");

	popWhenEmpty: assert property (@(posedge clock) disable iff (!rstN)
		!(pop && empty))
		else $error("addend buffer popped while empty");

	adderInput: assert property (@(posedge clock) disable iff (!rstN)
		!(addClaim && chainClaim))
		else $error("ADD and chain pulse both claim the adder input");

	// One result per cycle on the result port
	resultPort: assert property (@(posedge clock) disable iff (!rstN)
		!(addOut && mulOut))
		else $error("adder and plain multiplier results valid in the same cycle");

endmodule

bind addendBuffer maUnitAsserts u_bufferAsserts (
	.clock      (clock),
	.rstN       (rstN),
	.push       (push),
	.pop        (pop),
	.full       (full),
	.empty      (empty),
	.addClaim   (1'b0),
	.chainClaim (1'b0),
	.addOut     (1'b0),
	.mulOut     (1'b0)
);

bind maUnit maUnitAsserts u_unitAsserts (
	.clock      (clock),
	.rstN       (rstN),
	.push       (1'b0),
	.pop        (1'b0),
	.full       (1'b0),
	.empty      (1'b0),
	.addClaim   (acceptAdd),
	.chainClaim (chainPulse),
	.addOut     (addValid),
	.mulOut     (mulValid & ~mulChain)
);

`default_nettype wire

// ==== maUnit_tb.sv ====
//////////////////////////////
// Random test of maUnit against a cycle model of the issue rule
// Busy levels are obeyed except on a few deliberate cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module maUnit_tb;
	import maPkg::*;

	localparam int depthMul      = defaultDepthMul;
	localparam int depthAdd      = defaultDepthAdd;
	localparam int numIssue      = 2000;
	localparam int drainCycles   = depthMul + depthAdd + 2;	// Lets the last results leave
	localparam int timeoutCycles = numIssue + depthMul + depthAdd + 50;
	localparam int horizon       = numIssue + drainCycles + depthMul + depthAdd + 1;

	logic clock;
	logic rstN;
	logic en;
	opT   op;
	tagT  tag;
	dataT data1;
	dataT data2;
	dataT data3;
	logic valid;
	dataT result;
	tagT  resultTag;
	logic addBusy;
	logic mulBusy;

	//////////////////////////////
	// Reference model state
	//////////////////////////////

	// Indexed by cycle number, counted from the first issue cycle
	bit   portTaken [horizon];	// Result port reserved
	bit   adderTaken [horizon];	// Adder input held by a chain pulse
	bit   expValid [horizon];
	dataT expResult [horizon];
	tagT  expTag [horizon];

	integer seed;
	int     errorCount;
	int     checkCount;
	int     acceptCount;
	int     validCount;
	int     dropCount;
	int     cycleCount;
	bit     runDone;

	tbClock #(
		.halfPeriod  (10),
		.resetCycles (8)
	) u_clock (
		.clock (clock),
		.rstN  (rstN)
	);

	maUnit #(
		.depthMul (depthMul),
		.depthAdd (depthAdd)
	) u_dut (
		.clock     (clock),
		.rstN      (rstN),
		.en        (en),
		.op        (op),
		.tag       (tag),
		.data1     (data1),
		.data2     (data2),
		.data3     (data3),
		.valid     (valid),
		.result    (result),
		.resultTag (resultTag),
		.addBusy   (addBusy),
		.mulBusy   (mulBusy)
	);

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checkCount++;
		if (got !== want) begin
			errorCount++;
			$display("mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, got, want, $time);
		end
	endtask

	// ADD needs the adder input now and the port depthAdd later
	function automatic bit addBusyFor(input int n);
		return portTaken[n + depthAdd] | adderTaken[n];
	endfunction

	function automatic bit mulBusyFor(input int n, input opT o);
		if (o == opMulAdd) begin
			return adderTaken[n + depthMul] | portTaken[n + depthMul + depthAdd];
		end else begin
			return portTaken[n + depthMul];
		end
	endfunction

	// Claims the slots of an accepted operation and queues its result
	task automatic reserveAndQueue(input int n, input opT o);
		int due;
		case (o)
			opAdd: begin
				due = n + depthAdd;
				expResult[due] = data1 + data2;
			end
			opMul: begin
				due = n + depthMul;
				expResult[due] = data1 * data2;	// Low word only
			end
			default: begin
				due = n + depthMul + depthAdd;
				adderTaken[n + depthMul] = 1'b1;
				expResult[due] = data1 * data2 + data3;
			end
		endcase
		portTaken[due] = 1'b1;
		expValid[due]  = 1'b1;
		expTag[due]    = tag;
		acceptCount++;
	endtask

	//////////////////////////////
	// One issue cycle
	//////////////////////////////
	task automatic issueCycle(input int n, input bit issueOn);
		logic [31:0] r;
		opT          o;
		bit          legal;
		bit          busy;
		bit          drive;
		@(posedge clock);
		#1;
		r = $random(seed);
		case (r[2:0])
			3'd0, 3'd1: o = opAdd;
			3'd2, 3'd3: o = opMul;
			3'd7:       o = opT'(r[1:0]);	// Reserved code, no operation
			default:    o = opMulAdd;
		endcase
		legal = (o == opAdd) || (o == opMul) || (o == opMulAdd);
		busy  = (o == opAdd) ? addBusyFor(n) : mulBusyFor(n, o);
		drive = issueOn && (r[4:3] != 2'b00);
		if (drive && busy && legal) begin
			if (r[9:5] == 5'd0) begin
				dropCount++;	// Sent anyway, must vanish
			end else begin
				drive = 1'b0;
			end
		end
		en    = drive;
		op    = o;
		tag   = r[13:10];
		data1 = $random(seed);
		data2 = $random(seed);
		data3 = $random(seed);

		@(negedge clock);	// Outputs settled
		compareValue("addBusy", 32'(addBusy), 32'(addBusyFor(n)));
		compareValue("mulBusy", 32'(mulBusy), 32'(mulBusyFor(n, o)));
		compareValue("valid", 32'(valid), 32'(expValid[n]));
		if (expValid[n]) begin
			compareValue("result", result, expResult[n]);
			compareValue("resultTag", 32'(resultTag), 32'(expTag[n]));
		end
		if (valid) begin
			validCount++;
		end
		if (drive && legal && !busy) begin
			reserveAndQueue(n, o);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		seed        = 32'hc21dc9d3;
		errorCount  = 0;
		checkCount  = 0;
		acceptCount = 0;
		validCount  = 0;
		dropCount   = 0;
		cycleCount  = 0;
		runDone     = 1'b0;
		en          = 1'b0;
		op          = opAdd;
		tag         = '0;
		data1       = '0;
		data2       = '0;
		data3       = '0;

		wait (rstN === 1'b1);
		@(negedge clock);
		// Nothing in flight straight after reset
		compareValue("valid", 32'(valid), 32'd0);
		compareValue("addBusy", 32'(addBusy), 32'd0);
		compareValue("mulBusy", 32'(mulBusy), 32'd0);

		for (int n = 0; n < numIssue + drainCycles; n++) begin
			issueCycle(n, n < numIssue);
		end
		runDone = 1'b1;

		// One pulse per accepted operation over the whole run
		compareValue("validCount", validCount, acceptCount);

		$display("Done: %0d checks, %0d errors, %0d accepted, %0d dropped on purpose",
			checkCount, errorCount, acceptCount, dropCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Run limit in cycles after reset
	always @(posedge clock) begin
		if (rstN && !runDone) begin
			cycleCount++;
			if (cycleCount > timeoutCycles) begin
				$display("Timeout: test did not finish within %0d cycles", timeoutCycles);
				$display("Simulation failed");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
maPkg.sv
maAdder.sv
maMultiplier.sv
addendBuffer.sv
issueTracker.sv
maUnit.sv
tbClock.sv
maUnit_asserts.sv
maUnit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the maUnit testbench with Verilator and runs it
# Exit status is 0 only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module maUnit_tb -f flist.f -o simv || exit 1

simOut="$(./obj_dir/simv 2>&1)"
echo "$simOut"
echo "$simOut" | grep -qxF "Simulation completed successfully" && exit 0 || exit 1
